/* hsid_cfg.svh */
`ifndef HSID_CFG_SVH
`define HSID_CFG_SVH

// One band sample
`define HSID_DATA_WIDTH 16

// Vector length and band position
`define HSID_BANDS_WIDTH 8

// FIFO address bits, four entries per FIFO
`define HSID_BUFFER_WIDTH 2

// Spectral memory address bits
`define HSID_MEM_ADDR_WIDTH 8

`endif

/* hsid_data_pkg.sv */
`default_nettype none

`include "hsid_cfg.svh"

package hsid_data_pkg;

  typedef logic [`HSID_DATA_WIDTH-1:0] sample_t;     // One band sample
  typedef logic [`HSID_BANDS_WIDTH-1:0] band_cnt_t;  // Vector length or band index

  // Run command, sampled on the start pulse
  typedef struct packed {
    logic [`HSID_MEM_ADDR_WIDTH-1:0] base_a;  // First spectrum
    logic [`HSID_MEM_ADDR_WIDTH-1:0] base_b;  // Second spectrum
    band_cnt_t                       length;  // Bands per spectrum
  } run_cmd_t;

endpackage

`default_nettype wire

/* hsid_bus_pkg.sv */
`default_nettype none

`include "hsid_cfg.svh"

package hsid_bus_pkg;

  typedef logic req_id_t;  // 0 for fetcher a, 1 for fetcher b

  typedef struct packed {
    logic                            valid;
    logic [`HSID_MEM_ADDR_WIDTH-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                   valid;
    req_id_t                id;    // Requester that owns this word
    hsid_data_pkg::sample_t data;
  } mem_rsp_t;

  // Memory fill port used between runs
  typedef struct packed {
    logic                            en;
    logic [`HSID_MEM_ADDR_WIDTH-1:0] addr;
    hsid_data_pkg::sample_t          data;
  } load_t;

endpackage

`default_nettype wire

/* hsid_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module hsid_fifo #(
  parameter int ADDR_WIDTH = `HSID_BUFFER_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  hsid_data_pkg::sample_t data_in,
  input  logic [ADDR_WIDTH:0]    almost_full_threshold,
  output hsid_data_pkg::sample_t data_out,
  output logic                   full,
  output logic                   almost_full,
  output logic                   empty
);

  localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

  hsid_data_pkg::sample_t mem [1 << ADDR_WIDTH];

  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH:0]   count;  // Occupancy, 0 to DEPTH
  logic                  wr_ok;
  logic                  rd_ok;

  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign data_out    = mem[rd_ptr];  // Head entry, no read latency
  assign full        = (count == DEPTH);
  assign empty       = (count == '0);
  assign almost_full = (count >= almost_full_threshold);

  // Writers and readers outside must respect the flags
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
    else $error("hsid_fifo write while full");
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
    else $error("hsid_fifo read while empty");

endmodule

`default_nettype wire

/* vctr_fifo_strm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module vctr_fifo_strm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     v1_en,
  input  hsid_data_pkg::sample_t   v1_data,
  output logic                     v1_full,
  input  logic                     v2_en,
  input  hsid_data_pkg::sample_t   v2_data,
  output logic                     v2_full,
  input  logic                     data_out_en,
  output hsid_data_pkg::sample_t   data_out,
  output logic                     data_out_empty,
  input  hsid_data_pkg::band_cnt_t length,
  input  logic                     start,
  output logic                     done,
  output logic                     idle,
  output logic                     ready
);

  localparam int BUF_DEPTH = 2 ** `HSID_BUFFER_WIDTH;
  localparam logic [`HSID_BUFFER_WIDTH:0] IN_AF_LEVEL  = (`HSID_BUFFER_WIDTH+1)'(BUF_DEPTH);
  localparam logic [`HSID_BUFFER_WIDTH:0] OUT_AF_LEVEL = (`HSID_BUFFER_WIDTH+1)'(BUF_DEPTH - 2);

  typedef enum logic [1:0] {IDLE, COMPUTE, DONE} state_t;

  state_t                   state;
  state_t                   next_state;
  hsid_data_pkg::sample_t   v1_head;
  hsid_data_pkg::sample_t   v2_head;
  hsid_data_pkg::sample_t   pair_a;
  hsid_data_pkg::sample_t   pair_b;
  hsid_data_pkg::sample_t   sum_q;
  hsid_data_pkg::band_cnt_t len_q;
  hsid_data_pkg::band_cnt_t processed;  // Sums written to the output FIFO
  logic v1_fifo_full, v2_fifo_full;
  logic v1_empty, v2_empty;
  logic out_full, out_almost_full;
  logic pop, pair_vld, sum_vld;

  // Almost-full keeps room for the pairs still in the adder
  assign pop = (state == COMPUTE) && !v1_empty && !v2_empty && !out_almost_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      pair_vld  <= 1'b0;
      sum_vld   <= 1'b0;
      len_q     <= '0;
      processed <= '0;
    end else begin
      state    <= next_state;
      pair_vld <= pop;
      sum_vld  <= pair_vld;
      if (state == IDLE && start) begin
        len_q     <= length;  // Latch the run length
        processed <= '0;
      end else if (sum_vld) begin
        processed <= processed + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      pair_a <= v1_head;
      pair_b <= v2_head;
    end
    if (pair_vld) sum_q <= pair_a + pair_b;  // Wraps modulo 2^16
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (start) next_state = COMPUTE;
      COMPUTE: if (processed == len_q) next_state = DONE;
      DONE:    if (data_out_empty) next_state = IDLE;  // Wait for the drain
      default: next_state = IDLE;
    endcase
  end

  assign idle    = (state == IDLE);
  assign ready   = (state == COMPUTE);
  assign done    = (state == DONE);
  assign v1_full = v1_fifo_full || out_almost_full;
  assign v2_full = v2_fifo_full || out_almost_full;

  hsid_fifo u_fifo_v1 (
    .clk(clk), .rst_n(rst_n), .wr_en(v1_en), .rd_en(pop), .data_in(v1_data),
    .almost_full_threshold(IN_AF_LEVEL), .data_out(v1_head), .full(v1_fifo_full),
    .almost_full(), .empty(v1_empty)
  );

  hsid_fifo u_fifo_v2 (
    .clk(clk), .rst_n(rst_n), .wr_en(v2_en), .rd_en(pop), .data_in(v2_data),
    .almost_full_threshold(IN_AF_LEVEL), .data_out(v2_head), .full(v2_fifo_full),
    .almost_full(), .empty(v2_empty)
  );

  hsid_fifo u_fifo_out (
    .clk(clk), .rst_n(rst_n), .wr_en(sum_vld), .rd_en(data_out_en && !data_out_empty),
    .data_in(sum_q), .almost_full_threshold(OUT_AF_LEVEL), .data_out(data_out),
    .full(out_full), .almost_full(out_almost_full), .empty(data_out_empty)
  );

  a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
    state != IDLE |-> processed <= len_q)
    else $error("processed count passed the run length");
  // A popped pair must find room two cycles later
  a_room_for_sum : assert property (@(posedge clk) disable iff (!rst_n) pop |-> ##2 !out_full)
    else $error("sum reached a full output FIFO");

endmodule

`default_nettype wire

/* spectrum_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module spectrum_fetch #(
  parameter hsid_bus_pkg::req_id_t ID = 1'b0
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  logic [`HSID_MEM_ADDR_WIDTH-1:0] base,
  input  hsid_data_pkg::band_cnt_t        length,
  output hsid_bus_pkg::mem_req_t          req,
  input  logic                            grant,
  input  hsid_bus_pkg::mem_rsp_t          rsp,
  output logic                            in_en,
  output hsid_data_pkg::sample_t          in_data,
  input  logic                            in_full
);

  logic [`HSID_MEM_ADDR_WIDTH-1:0] addr_q;
  hsid_data_pkg::band_cnt_t        remaining;    // Bands not yet requested
  logic                            pend;         // Raised, waiting for grant
  logic                            outstanding;  // Granted, waiting for data
  logic                            issue;
  logic                            rsp_hit;

  assign issue   = !pend && !outstanding && (remaining != '0) && !in_full;
  assign rsp_hit = rsp.valid && (rsp.id == ID);
  assign req     = '{valid: pend || issue, addr: addr_q};  // Held until granted

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q      <= '0;
      remaining   <= '0;
      pend        <= 1'b0;
      outstanding <= 1'b0;
    end else if (start) begin
      addr_q      <= base;
      remaining   <= length;
      pend        <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      if (rsp_hit) outstanding <= 1'b0;
      if (req.valid && grant) begin
        addr_q      <= addr_q + 1'b1;
        remaining   <= remaining - 1'b1;
        pend        <= 1'b0;
        outstanding <= 1'b1;
      end else if (issue) begin
        pend <= 1'b1;  // Lost arbitration this cycle
      end
    end
  end

  assign in_en   = rsp_hit;  // Straight into the input FIFO
  assign in_data = rsp.data;

  // Memory only answers what this fetcher was granted
  a_rsp_expected : assert property (@(posedge clk) disable iff (!rst_n) rsp_hit |-> outstanding)
    else $error("fetcher %0d got an unexpected response", ID);

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module mem_arbiter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  hsid_bus_pkg::mem_req_t          req_a,
  input  hsid_bus_pkg::mem_req_t          req_b,
  output logic                            grant_a,
  output logic                            grant_b,
  output logic [`HSID_MEM_ADDR_WIDTH-1:0] mem_addr,
  output logic                            mem_rd,
  output hsid_bus_pkg::req_id_t           mem_id
);

  logic prio;  // 0 favours a, 1 favours b

  always_comb begin
    grant_a = req_a.valid && (!req_b.valid || !prio);
    grant_b = req_b.valid && (!req_a.valid || prio);
  end

  assign mem_rd   = grant_a || grant_b;
  assign mem_addr = grant_b ? req_b.addr : req_a.addr;
  assign mem_id   = grant_b ? 1'b1 : 1'b0;  // Tag follows the winner

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio <= 1'b0;
    end else if (mem_rd) begin
      prio <= !prio;  // Alternate after every grant
    end
  end

  // A held request that loses arbitration wins in the next cycle
  a_a_served : assert property (@(posedge clk) disable iff (!rst_n)
    req_a.valid && !grant_a |=> grant_a)
    else $error("fetcher a not served after losing arbitration");
  a_b_served : assert property (@(posedge clk) disable iff (!rst_n)
    req_b.valid && !grant_b |=> grant_b)
    else $error("fetcher b not served after losing arbitration");

endmodule

`default_nettype wire

/* spectrum_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module spectrum_mem (
  input  logic                            clk,
  input  hsid_bus_pkg::load_t             load,
  input  logic                            mem_rd,
  input  logic [`HSID_MEM_ADDR_WIDTH-1:0] mem_addr,
  input  hsid_bus_pkg::req_id_t           mem_id,
  output hsid_bus_pkg::mem_rsp_t          rsp
);

  hsid_data_pkg::sample_t mem [1 << `HSID_MEM_ADDR_WIDTH];

  logic                   rd_vld = 1'b0;  // Power-up value, no reset pin here
  hsid_bus_pkg::req_id_t  rd_id;
  hsid_data_pkg::sample_t rd_data;

  always_ff @(posedge clk) begin
    if (load.en) mem[load.addr] <= load.data;  // Fill port, idle only
    rd_vld <= mem_rd;
    if (mem_rd) begin
      rd_id   <= mem_id;
      rd_data <= mem[mem_addr];
    end
  end

  assign rsp = '{valid: rd_vld, id: rd_id, data: rd_data};

endmodule

`default_nettype wire

/* hsid_vctr_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module hsid_vctr_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  hsid_bus_pkg::load_t     load,
  input  logic                    start,
  input  hsid_data_pkg::run_cmd_t cmd,
  input  logic                    data_out_en,
  output hsid_data_pkg::sample_t  data_out,
  output logic                    data_out_empty,
  output logic                    done,
  output logic                    idle,
  output logic                    ready
);

  hsid_bus_pkg::mem_req_t          req_a, req_b;
  hsid_bus_pkg::mem_rsp_t          rsp;
  hsid_bus_pkg::req_id_t           mem_id;
  logic [`HSID_MEM_ADDR_WIDTH-1:0] mem_addr;
  logic                            mem_rd, grant_a, grant_b;
  logic                            v1_en, v1_full, v2_en, v2_full;
  hsid_data_pkg::sample_t          v1_data, v2_data;

  spectrum_mem u_spectrum_mem (
    .clk(clk), .load(load), .mem_rd(mem_rd), .mem_addr(mem_addr), .mem_id(mem_id), .rsp(rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk(clk), .rst_n(rst_n), .req_a(req_a), .req_b(req_b), .grant_a(grant_a),
    .grant_b(grant_b), .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_id(mem_id)
  );

  spectrum_fetch #(.ID(1'b0)) u_fetch_a (
    .clk(clk), .rst_n(rst_n), .start(start), .base(cmd.base_a), .length(cmd.length),
    .req(req_a), .grant(grant_a), .rsp(rsp), .in_en(v1_en), .in_data(v1_data),
    .in_full(v1_full)
  );

  spectrum_fetch #(.ID(1'b1)) u_fetch_b (
    .clk(clk), .rst_n(rst_n), .start(start), .base(cmd.base_b), .length(cmd.length),
    .req(req_b), .grant(grant_b), .rsp(rsp), .in_en(v2_en), .in_data(v2_data),
    .in_full(v2_full)
  );

  vctr_fifo_strm u_vctr_fifo_strm (
    .clk(clk), .rst_n(rst_n),
    .v1_en(v1_en), .v1_data(v1_data), .v1_full(v1_full),
    .v2_en(v2_en), .v2_data(v2_data), .v2_full(v2_full),
    .data_out_en(data_out_en), .data_out(data_out), .data_out_empty(data_out_empty),
    .length(cmd.length), .start(start), .done(done), .idle(idle), .ready(ready)
  );

endmodule

`default_nettype wire

/* tb_hsid_vctr.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hsid_cfg.svh"

module tb_hsid_vctr;

  localparam string STIM_FILE = "hsid_stim.txt";
  localparam int    MEM_WORDS = 1 << `HSID_MEM_ADDR_WIDTH;

  logic                    clk;
  logic                    rst_n;
  hsid_bus_pkg::load_t     load;
  logic                    start;
  hsid_data_pkg::run_cmd_t cmd;
  logic                    data_out_en;
  hsid_data_pkg::sample_t  data_out;
  logic                    data_out_empty;
  logic                    done;
  logic                    idle;
  logic                    ready;

  int errors   = 0;
  int timeouts = 0;
  int cycles   = 0;
  int limit    = 20;     // Slack for reset before runs and loads are added
  int seed     = 39368;

  // Parsed stimulus in file order
  byte                             op_kind[$];
  int                              op_index[$];   // First load word or run number
  int                              op_count[$];
  logic [`HSID_MEM_ADDR_WIDTH-1:0] load_addr[$];
  hsid_data_pkg::sample_t          load_data[$];
  hsid_data_pkg::run_cmd_t         run_cmd[$];
  int                              run_first[$];  // Index of band 0 in exp_q
  int                              run_exp_cnt[$];
  hsid_data_pkg::sample_t          exp_q[$];

  hsid_vctr_top u_hsid_vctr_top (
    .clk(clk), .rst_n(rst_n), .load(load), .start(start), .cmd(cmd),
    .data_out_en(data_out_en), .data_out(data_out), .data_out_empty(data_out_empty),
    .done(done), .idle(idle), .ready(ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    #2;
    data_out_en = ({$random(seed)} % 10) < 6;  // Reader stalls about 40 percent
  end

  task automatic finish_run();
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    #1;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    timeouts++;
    $display("timeout: the runs did not finish within %0d cycles", limit);
    finish_run();
  end

  task automatic check_sample(input hsid_data_pkg::sample_t got,
                              input hsid_data_pkg::sample_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input logic exp_idle, input logic exp_ready,
                              input logic exp_done, input logic exp_empty, input string what);
    if ({idle, ready, done, data_out_empty} !== {exp_idle, exp_ready, exp_done, exp_empty}) begin
      errors++;
      $display("mismatch at %0t: %s idle/ready/done/empty %b%b%b%b, expected %b%b%b%b",
               $time, what, idle, ready, done, data_out_empty,
               exp_idle, exp_ready, exp_done, exp_empty);
    end
  endtask

  task automatic read_stim();
    int                      fd;
    int                      code;
    int                      n;
    int                      i;
    int                      r;
    int                      k;
    byte                     tag;
    string                   line;
    logic [31:0]             v;
    logic [31:0]             w;
    logic [31:0]             x;
    hsid_data_pkg::run_cmd_t rc;
    hsid_data_pkg::sample_t  sum;
    hsid_data_pkg::sample_t  shadow [MEM_WORDS];  // Memory image as loaded so far
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open %s", STIM_FILE);
      return;
    end
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": code = $fgets(line, fd);
        "L": begin
          code = $fscanf(fd, "%h %d", v, n);
          op_kind.push_back(tag);
          op_index.push_back(load_addr.size());
          op_count.push_back(n);
          for (i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", w);
            k = (v + i) % MEM_WORDS;
            load_addr.push_back(k[`HSID_MEM_ADDR_WIDTH-1:0]);
            load_data.push_back(w[`HSID_DATA_WIDTH-1:0]);
            shadow[k] = w[`HSID_DATA_WIDTH-1:0];
          end
          limit += n;
        end
        "R": begin
          code = $fscanf(fd, "%h %h %d", v, w, x);
          rc.base_a = v[`HSID_MEM_ADDR_WIDTH-1:0];
          rc.base_b = w[`HSID_MEM_ADDR_WIDTH-1:0];
          rc.length = x[`HSID_BANDS_WIDTH-1:0];
          op_kind.push_back(tag);
          op_index.push_back(run_cmd.size());
          op_count.push_back(1);
          run_cmd.push_back(rc);
          run_first.push_back(exp_q.size());
          run_exp_cnt.push_back(0);
          limit += 10 * int'(rc.length) + 40;
        end
        "E": begin
          code = $fscanf(fd, "%d", n);
          r = run_cmd.size() - 1;
          for (i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", v);
            if (r < 0) begin
              errors++;
              $display("expected sum in %s comes before any run", STIM_FILE);
            end else begin
              rc  = run_cmd[r];
              k   = run_exp_cnt[r];
              sum = shadow[(int'(rc.base_a) + k) % MEM_WORDS]
                  + shadow[(int'(rc.base_b) + k) % MEM_WORDS];  // Wraps modulo 2^16
              if (v[`HSID_DATA_WIDTH-1:0] !== sum) begin
                errors++;
                $display("stim file run %0d band %0d lists %h but the loaded words give %h",
                         r, k, v[`HSID_DATA_WIDTH-1:0], sum);
              end
              exp_q.push_back(v[`HSID_DATA_WIDTH-1:0]);
              run_exp_cnt[r] = k + 1;
            end
          end
        end
        default: begin
          errors++;
          $display("unknown line tag %c in %s", tag, STIM_FILE);
          code = $fgets(line, fd);
        end
      endcase
    end
    $fclose(fd);
    for (r = 0; r < run_cmd.size(); r++) begin
      if (run_exp_cnt[r] != int'(run_cmd[r].length)) begin
        errors++;
        $display("run %0d lists %0d expected sums for %0d bands",
                 r, run_exp_cnt[r], run_cmd[r].length);
      end
    end
  endtask

  task automatic do_load(input int first, input int count);
    int i;
    for (i = 0; i < count; i++) begin
      @(posedge clk);
      #2;
      load = '{en: 1'b1, addr: load_addr[first + i], data: load_data[first + i]};
    end
    @(posedge clk);
    #2;
    load.en = 1'b0;
  endtask

  task automatic do_run(input int r);
    int got;
    bit done_seen;
    got       = 0;
    done_seen = 1'b0;
    @(posedge clk);
    #2;
    cmd   = run_cmd[r];
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    @(negedge clk);
    check_status(1'b0, 1'b1, 1'b0, 1'b1, $sformatf("run %0d after start", r));
    while (got < int'(run_cmd[r].length)) begin
      @(negedge clk);
      if (done_seen && !done && !idle) begin
        errors++;
        $display("run %0d dropped done before the last sample was read", r);
      end
      done_seen |= done;
      if (idle) begin
        errors++;
        $display("run %0d went idle after only %0d samples", r, got);
      end
      if (data_out_en && !data_out_empty) begin  // Read happens on the next edge
        if (got < run_exp_cnt[r]) begin
          check_sample(data_out, exp_q[run_first[r] + got], $sformatf("run %0d band %0d", r, got));
        end
        got++;
      end
    end
    while (!idle) begin
      @(negedge clk);
      if (done_seen && !done && !idle) begin
        errors++;
        $display("run %0d dropped done before going idle", r);
      end
      done_seen |= done;
      if (data_out_en && !data_out_empty) begin
        errors++;
        $display("run %0d returned more than %0d samples", r, got);
      end
    end
    if (!done_seen) begin
      errors++;
      $display("done never rose during run %0d", r);
    end
    check_status(1'b1, 1'b0, 1'b0, 1'b1, $sformatf("run %0d end", r));
  endtask

  initial begin
    int k;
    rst_n       = 1'b0;
    load        = '0;
    start       = 1'b0;
    cmd         = '0;
    data_out_en = 1'b0;
    read_stim();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_status(1'b1, 1'b0, 1'b0, 1'b1, "after reset");
    for (k = 0; k < op_kind.size(); k++) begin
      if (op_kind[k] == "L") begin
        do_load(op_index[k], op_count[k]);
      end else begin
        do_run(op_index[k]);
      end
    end
    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

/* hsid_stim.txt */
# L addr n word...  loads n words from addr upward (addr and words hex, n decimal)
# R base_a base_b length (length decimal), then E n sum...  expected sums in band order
L 00 8 0001 0002 0003 0004 0005 0006 0007 0008
L 08 8 0010 0020 0030 0040 0050 0060 0070 0080
L 10 8 ffff 8000 fff0 1234 0001 8000 0020 f000
L 18 8 0100 0200 0300 0400 0500 0600 0700 0800
L 20 8 1000 2000 3000 4000 5000 6000 7000 8000
L 28 8 0011 0022 0033 0044 0055 0066 0077 0088
# Plain sums
R 00 08 8
E 8 0011 0022 0033 0044 0055 0066 0077 0088
# Sums that wrap
R 10 14 4
E 4 0000 0000 0010 0234
# Both fetchers on the same words
R 00 00 8
E 8 0002 0004 0006 0008 000a 000c 000e 0010
# Single band
R 12 13 1
E 1 1224
# Long run across all loaded words
R 00 08 40
E 8 0011 0022 0033 0044 0055 0066 0077 0088
E 8 000f 8020 0020 1274 0051 8060 0090 f080
E 8 00ff 8200 02f0 1634 0501 8600 0720 f800
E 8 1100 2200 3300 4400 5500 6600 7700 8800
E 8 1011 2022 3033 4044 5055 6066 7077 8088

/* files.f */
+incdir+.
hsid_data_pkg.sv
hsid_bus_pkg.sv
hsid_fifo.sv
vctr_fifo_strm.sv
spectrum_fetch.sv
mem_arbiter.sv
spectrum_mem.sv
hsid_vctr_top.sv
tb_hsid_vctr.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hsid_vctr
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail unless it passes"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILE_LIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF ">>> PASS"

clean:
	rm -rf $(OBJ_DIR)
